//--- verilog/raw_rgb_pkg.sv
`default_nettype none

package raw_rgb_pkg;

    // ############################################################
    // Widths and phase codes
    // ############################################################

    // Widest pixel that a stream field can carry.
    // Each module uses only the low DATA_BITS bits of it.
    localparam int PIX_W = 16;

    // Bayer phase codes as seen on param_phase.
    // Bit 0 is the column parity of the red sites and bit 1 their row parity.
    localparam logic [1:0] PHASE_RGGB = 2'd0;
    localparam logic [1:0] PHASE_GRBG = 2'd1;
    localparam logic [1:0] PHASE_GBRG = 2'd2;
    localparam logic [1:0] PHASE_BGGR = 2'd3;

    // Colour site of one pixel.
    // The code is {row parity ^ phase[1], column parity ^ phase[0]}.
    typedef enum logic [1:0] {
        site_r  = 2'b00,
        site_gr = 2'b01,
        site_gb = 2'b10,
        site_b  = 2'b11
    } site_t;

    // ############################################################
    // Stream and window words
    // ############################################################

    // One raw pixel on the input stream.
    typedef struct packed {
        logic [PIX_W-1:0] data;
        logic             sof;
        logic             eol;
    } raw_beat_t;

    // Frame markers that ride alongside a pixel through the pipeline.
    typedef struct packed {
        logic sof;
        logic eol;
    } flags_t;

    // 3x3 neighbourhood in row-major order, pix[0] is the top-left pixel.
    typedef struct packed {
        logic [8:0][PIX_W-1:0] pix;
        site_t                 site;
        logic                  sof;
        logic                  eol;
    } window_t;

    // One RGB pixel on the output stream.
    typedef struct packed {
        logic [PIX_W-1:0] r;
        logic [PIX_W-1:0] g;
        logic [PIX_W-1:0] b;
        logic             sof;
        logic             eol;
    } rgb_beat_t;

endpackage

`default_nettype wire

//--- verilog/raw_window.sv
`default_nettype none

module raw_window #(
    parameter int DATA_BITS = 10,
    parameter int MAX_COLS  = 1024
) (
    input  var logic                   clk,
    input  var logic                   rst_n,
    input  var logic                   advance,
    input  var logic                   s_valid,
    input  var raw_rgb_pkg::raw_beat_t s_beat,
    input  var logic                   in_update_req,
    input  var logic [1:0]             param_phase,
    output var logic                   win_valid,
    output var raw_rgb_pkg::window_t   win
);
    import raw_rgb_pkg::*;

    // One extra column bit lets an overlong line show up in the assertion.
    localparam int ADDR_BITS = $clog2(MAX_COLS);
    localparam int COL_BITS  = ADDR_BITS + 1;

    logic                 accept;
    logic [COL_BITS-1:0]  col_cnt;
    logic [COL_BITS-1:0]  cur_col;
    logic [ADDR_BITS-1:0] addr;
    logic [1:0]           row_lvl;
    logic [1:0]           cur_row_lvl;
    logic                 row_par;
    logic                 cur_row_par;
    logic [1:0]           phase;
    logic                 pending;
    logic [DATA_BITS-1:0] pix_in;
    logic [DATA_BITS-1:0] pix_near;
    logic [DATA_BITS-1:0] pix_far;

    // The near buffer holds row r-1, the far buffer holds row r-2.
    logic [DATA_BITS-1:0] line_near [MAX_COLS];
    logic [DATA_BITS-1:0] line_far  [MAX_COLS];

    // ############################################################
    // Position tracking
    // ############################################################

    assign accept = advance && s_valid;

    // A beat with sof is always column 0 of row 0, whatever the counters say.
    assign cur_col     = s_beat.sof ? '0 : col_cnt;
    assign cur_row_lvl = s_beat.sof ? 2'd0 : row_lvl;
    assign cur_row_par = s_beat.sof ? 1'b0 : row_par;
    assign addr        = cur_col[ADDR_BITS-1:0];

    // row_lvl counts 0, 1, 2 and then sticks at 3.
    // Only "row 2" and "row 2 or later" matter here, and parity is kept on its own.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_lvl <= 2'd0;
            row_par <= 1'b0;
        end else if (accept) begin
            if (s_beat.eol) begin
                col_cnt <= '0;
                row_lvl <= (cur_row_lvl == 2'd3) ? 2'd3 : cur_row_lvl + 2'd1;
                row_par <= ~cur_row_par;
            end else begin
                col_cnt <= cur_col + COL_BITS'(1);
                row_lvl <= cur_row_lvl;
                row_par <= cur_row_par;
            end
        end
    end

    // A request is held until the next accepted frame start.
    // The new phase then applies to that whole frame, since its first
    // output pixel lies two rows further down.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase   <= PHASE_RGGB;
            pending <= 1'b0;
        end else begin
            if (accept && s_beat.sof && pending) begin
                phase <= param_phase;
            end
            pending <= in_update_req || (pending && !(accept && s_beat.sof));
        end
    end

    // ############################################################
    // Line buffers and window
    // ############################################################

    assign pix_in   = s_beat.data[DATA_BITS-1:0];
    assign pix_near = line_near[addr];
    assign pix_far  = line_far[addr];

    // Each column moves down one buffer as the new row overwrites it.
    always_ff @(posedge clk) begin
        if (accept) begin
            line_near[addr] <= pix_in;
            line_far[addr]  <= pix_near;
        end
    end

    // The new column enters on the right, so after pixel (r, c) the
    // window spans rows r-2..r and columns c-2..c.
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int k = 0; k < 3; k++) begin
                win.pix[3*k]   <= win.pix[3*k+1];
                win.pix[3*k+1] <= win.pix[3*k+2];
            end
            win.pix[2] <= PIX_W'(pix_far);
            win.pix[5] <= PIX_W'(pix_near);
            win.pix[8] <= PIX_W'(pix_in);
            // Centre is one row up and one column left, so both parities flip.
            win.site <= site_t'({~cur_row_par ^ phase[1], ~cur_col[0] ^ phase[0]});
            win.sof  <= (cur_row_lvl == 2'd2) && (cur_col == COL_BITS'(2));
            win.eol  <= s_beat.eol;
        end
    end

    // Border crop. Windows that reach past the top or left edge never leave.
    // The right and bottom edges drop out by themselves.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else if (advance) begin
            win_valid <= accept && (cur_row_lvl >= 2'd2) && (cur_col >= COL_BITS'(2));
        end
    end

    // Lines longer than the buffer depth would wrap and corrupt earlier columns.
    a_col_in_range : assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |-> (cur_col < COL_BITS'(MAX_COLS))
    );

endmodule

`default_nettype wire

//--- verilog/green_interp.sv
`default_nettype none

module green_interp #(
    parameter int DATA_BITS = 10
) (
    input  var logic                 clk,
    input  var logic                 rst_n,
    input  var logic                 advance,
    input  var logic                 win_valid,
    input  var raw_rgb_pkg::window_t win,
    output var logic                 green_valid,
    output var logic [DATA_BITS-1:0] green_val,
    output var raw_rgb_pkg::flags_t  green_flags
);
    import raw_rgb_pkg::*;

    logic [DATA_BITS-1:0] north;
    logic [DATA_BITS-1:0] west;
    logic [DATA_BITS-1:0] centre;
    logic [DATA_BITS-1:0] east;
    logic [DATA_BITS-1:0] south;
    logic [DATA_BITS+1:0] cross_sum;
    logic [DATA_BITS-1:0] green_next;

    // Orthogonal neighbours of the centre, pix[4].
    assign north  = win.pix[1][DATA_BITS-1:0];
    assign west   = win.pix[3][DATA_BITS-1:0];
    assign centre = win.pix[4][DATA_BITS-1:0];
    assign east   = win.pix[5][DATA_BITS-1:0];
    assign south  = win.pix[7][DATA_BITS-1:0];

    // Two guard bits keep the four-way sum exact.
    assign cross_sum = (DATA_BITS+2)'(north) + (DATA_BITS+2)'(west)
                     + (DATA_BITS+2)'(east) + (DATA_BITS+2)'(south);

    // Green sites already hold green.
    // At red and blue sites all four orthogonal neighbours are green.
    always_comb begin
        if (win.site == site_gr || win.site == site_gb) begin
            green_next = centre;
        end else begin
            green_next = cross_sum[DATA_BITS+1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            green_valid <= 1'b0;
        end else if (advance) begin
            green_valid <= win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            green_val       <= green_next;
            green_flags.sof <= win.sof;
            green_flags.eol <= win.eol;
        end
    end

endmodule

`default_nettype wire

//--- verilog/red_blue_interp.sv
`default_nettype none

module red_blue_interp #(
    parameter int DATA_BITS = 10
) (
    input  var logic                 clk,
    input  var logic                 rst_n,
    input  var logic                 advance,
    input  var logic                 win_valid,
    input  var raw_rgb_pkg::window_t win,
    output var logic                 rb_valid,
    output var logic [DATA_BITS-1:0] red_val,
    output var logic [DATA_BITS-1:0] blue_val
);
    import raw_rgb_pkg::*;

    logic [DATA_BITS-1:0] centre;
    logic [DATA_BITS+1:0] diag_sum;
    logic [DATA_BITS:0]   horiz_sum;
    logic [DATA_BITS:0]   vert_sum;
    logic [DATA_BITS-1:0] diag_mean;
    logic [DATA_BITS-1:0] horiz_mean;
    logic [DATA_BITS-1:0] vert_mean;
    logic [DATA_BITS-1:0] red_next;
    logic [DATA_BITS-1:0] blue_next;

    assign centre = win.pix[4][DATA_BITS-1:0];

    // ############################################################
    // Neighbour means
    // ############################################################

    // Corners of the window.
    // Around a red site they are all blue, and the other way round.
    assign diag_sum = (DATA_BITS+2)'(win.pix[0][DATA_BITS-1:0])
                    + (DATA_BITS+2)'(win.pix[2][DATA_BITS-1:0])
                    + (DATA_BITS+2)'(win.pix[6][DATA_BITS-1:0])
                    + (DATA_BITS+2)'(win.pix[8][DATA_BITS-1:0]);

    // Left and right share the centre's row colour.
    assign horiz_sum = (DATA_BITS+1)'(win.pix[3][DATA_BITS-1:0])
                     + (DATA_BITS+1)'(win.pix[5][DATA_BITS-1:0]);

    // Up and down carry the colour of the other row type.
    assign vert_sum = (DATA_BITS+1)'(win.pix[1][DATA_BITS-1:0])
                    + (DATA_BITS+1)'(win.pix[7][DATA_BITS-1:0]);

    // All means truncate.
    assign diag_mean  = diag_sum[DATA_BITS+1:2];
    assign horiz_mean = horiz_sum[DATA_BITS:1];
    assign vert_mean  = vert_sum[DATA_BITS:1];

    // ############################################################
    // Site selection
    // ############################################################

    // On a red row the horizontal neighbours of a green pixel are red.
    // On a blue row they are blue.
    always_comb begin
        case (win.site)
            site_r: begin
                red_next  = centre;
                blue_next = diag_mean;
            end
            site_b: begin
                red_next  = diag_mean;
                blue_next = centre;
            end
            site_gr: begin
                red_next  = horiz_mean;
                blue_next = vert_mean;
            end
            default: begin
                red_next  = vert_mean;
                blue_next = horiz_mean;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rb_valid <= 1'b0;
        end else if (advance) begin
            rb_valid <= win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            red_val  <= red_next;
            blue_val <= blue_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rgb_assemble.sv
`default_nettype none

module rgb_assemble #(
    parameter int DATA_BITS = 10
) (
    input  var logic                   clk,
    input  var logic                   rst_n,
    input  var logic                   green_valid,
    input  var logic [DATA_BITS-1:0]   green_val,
    input  var raw_rgb_pkg::flags_t    green_flags,
    input  var logic                   rb_valid,
    input  var logic [DATA_BITS-1:0]   red_val,
    input  var logic [DATA_BITS-1:0]   blue_val,
    input  var logic                   m_ready,
    output var logic                   advance,
    output var logic                   m_valid,
    output var raw_rgb_pkg::rgb_beat_t m_beat
);
    import raw_rgb_pkg::*;

    // ############################################################
    // Stall control
    // ############################################################

    // The whole pipeline moves when the output slot is free or being drained.
    // Every stage upstream freezes on the same signal, so nothing needs
    // its own skid buffer.
    assign advance = !m_valid || m_ready;

    // Both interpolators load on the same enable from the same window,
    // so their valids always agree.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
        end else if (advance) begin
            m_valid <= green_valid && rb_valid;
        end
    end

    // ############################################################
    // Output register
    // ############################################################

    // Flags come from the green path. The red/blue path carries the same ones.
    always_ff @(posedge clk) begin
        if (advance && green_valid) begin
            m_beat.r   <= PIX_W'(red_val);
            m_beat.g   <= PIX_W'(green_val);
            m_beat.b   <= PIX_W'(blue_val);
            m_beat.sof <= green_flags.sof;
            m_beat.eol <= green_flags.eol;
        end
    end

    // The two interpolators are separate modules on one enable.
    // A split here means one of them ran out of step.
    a_paths_aligned : assert property (
        @(posedge clk) disable iff (!rst_n)
        green_valid == rb_valid
    );

    // A stalled beat stays put until the sink takes it.
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_beat))
    );

endmodule

`default_nettype wire

//--- verilog/video_raw_to_rgb.sv
`default_nettype none

module video_raw_to_rgb #(
    parameter int DATA_BITS = 10,
    parameter int MAX_COLS  = 1024
) (
    input  var logic                   clk,
    input  var logic                   rst_n,
    input  var logic                   s_valid,
    output var logic                   s_ready,
    input  var raw_rgb_pkg::raw_beat_t s_beat,
    output var logic                   m_valid,
    input  var logic                   m_ready,
    output var raw_rgb_pkg::rgb_beat_t m_beat,
    input  var logic                   in_update_req,
    input  var logic [1:0]             param_phase
);
    import raw_rgb_pkg::*;

    // Single pipeline enable from the assembler.
    logic                 advance;

    // Window stage to both interpolators.
    logic                 win_valid;
    window_t              win;

    // Interpolator results into the assembler.
    logic                 green_valid;
    logic [DATA_BITS-1:0] green_val;
    flags_t               green_flags;
    logic                 rb_valid;
    logic [DATA_BITS-1:0] red_val;
    logic [DATA_BITS-1:0] blue_val;

    // ############################################################
    // Window stage
    // ############################################################

    raw_window #(
        .DATA_BITS (DATA_BITS),
        .MAX_COLS  (MAX_COLS)
    ) u_raw_window (
        .clk           (clk),
        .rst_n         (rst_n),
        .advance       (advance),
        .s_valid       (s_valid),
        .s_beat        (s_beat),
        .in_update_req (in_update_req),
        .param_phase   (param_phase),
        .win_valid     (win_valid),
        .win           (win)
    );

    // ############################################################
    // Interpolators, side by side on one window
    // ############################################################

    green_interp #(
        .DATA_BITS (DATA_BITS)
    ) u_green_interp (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .win_valid   (win_valid),
        .win         (win),
        .green_valid (green_valid),
        .green_val   (green_val),
        .green_flags (green_flags)
    );

    red_blue_interp #(
        .DATA_BITS (DATA_BITS)
    ) u_red_blue_interp (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .win_valid (win_valid),
        .win       (win),
        .rb_valid  (rb_valid),
        .red_val   (red_val),
        .blue_val  (blue_val)
    );

    // Output register and stall control.
    rgb_assemble #(
        .DATA_BITS (DATA_BITS)
    ) u_rgb_assemble (
        .clk         (clk),
        .rst_n       (rst_n),
        .green_valid (green_valid),
        .green_val   (green_val),
        .green_flags (green_flags),
        .rb_valid    (rb_valid),
        .red_val     (red_val),
        .blue_val    (blue_val),
        .m_ready     (m_ready),
        .advance     (advance),
        .m_valid     (m_valid),
        .m_beat      (m_beat)
    );

    // Input is taken exactly when the pipeline moves.
    assign s_ready = advance;

endmodule

`default_nettype wire

//--- dv/rgb_checker.sv
`default_nettype none

module rgb_checker #(
    parameter int DATA_BITS = 10
) (
    input  var logic                   clk,
    input  var logic                   rst_n,
    input  var logic                   s_valid,
    input  var logic                   s_ready,
    input  var raw_rgb_pkg::raw_beat_t s_beat,
    input  var logic                   m_valid,
    input  var logic                   m_ready,
    input  var raw_rgb_pkg::rgb_beat_t m_beat,
    input  var logic                   in_update_req,
    input  var logic [1:0]             param_phase,
    output int                         error_count,
    output int                         beat_count
);
    import raw_rgb_pkg::*;

    localparam int ROWS = 16;
    localparam int COLS = 32;

    // Raw pixels of the frame in flight, indexed by input row and column.
    int         fpix [ROWS][COLS];
    int         row;
    int         col;
    int         frame_w;
    int         out_idx;
    logic [1:0] frame_phase;
    logic       pending;
    logic       first_edge;
    logic       was_stalled;
    rgb_beat_t  held_beat;
    rgb_beat_t  exp_q [$];

    // ############################################################
    // Reference demosaic
    // ############################################################

    // Expected RGB for the pixel centred at input (cr, cc) of the current frame.
    // Site comes from the centre's parity and the phase latched at this frame's sof.
    function automatic rgb_beat_t model_pixel(input int cr, input int cc);
        rgb_beat_t  px;
        site_t      site;
        int         ctr;
        int         ortho;
        int         diag;
        int         horiz;
        int         vert;
        ctr   = fpix[cr][cc];
        ortho = (fpix[cr-1][cc] + fpix[cr+1][cc] + fpix[cr][cc-1] + fpix[cr][cc+1]) / 4;
        diag  = (fpix[cr-1][cc-1] + fpix[cr-1][cc+1]
              + fpix[cr+1][cc-1] + fpix[cr+1][cc+1]) / 4;
        horiz = (fpix[cr][cc-1] + fpix[cr][cc+1]) / 2;
        vert  = (fpix[cr-1][cc] + fpix[cr+1][cc]) / 2;
        site  = site_t'({cr[0] ^ frame_phase[1], cc[0] ^ frame_phase[0]});
        px    = '0;
        case (site)
            site_r: begin
                px.r = PIX_W'(ctr);
                px.g = PIX_W'(ortho);
                px.b = PIX_W'(diag);
            end
            site_gr: begin
                px.r = PIX_W'(horiz);
                px.g = PIX_W'(ctr);
                px.b = PIX_W'(vert);
            end
            site_gb: begin
                px.r = PIX_W'(vert);
                px.g = PIX_W'(ctr);
                px.b = PIX_W'(horiz);
            end
            default: begin
                px.r = PIX_W'(diag);
                px.g = PIX_W'(ortho);
                px.b = PIX_W'(ctr);
            end
        endcase
        return px;
    endfunction

    task automatic compare_field(input string name, input int want, input int got);
        if (want != got) begin
            error_count++;
            $display("Fail at time %0t: %s expected %0d, got %0d", $time, name, want, got);
        end
    endtask

    // ############################################################
    // Per-cycle checking
    // ############################################################

    // Everything is sampled at the rising edge, before the DUT registers update.
    always @(posedge clk) begin
        rgb_beat_t want;
        logic      accept;
        accept = s_valid && s_ready;
        if (!rst_n) begin
            row         = 0;
            col         = 0;
            frame_w     = 0;
            out_idx     = 0;
            frame_phase = PHASE_RGGB;
            pending     = 1'b0;
            first_edge  = 1'b1;
            was_stalled = 1'b0;
            error_count = 0;
            beat_count  = 0;
            exp_q.delete();
        end else begin
            if (first_edge && m_valid !== 1'b0) begin
                error_count++;
                $display("m_valid is not low on the first cycle after reset at time %0t", $time);
            end
            first_edge = 1'b0;

            // A stalled beat must stay exactly as it was.
            if (was_stalled) begin
                if (!m_valid) begin
                    error_count++;
                    $display("m_valid dropped while the beat was stalled at time %0t", $time);
                end else if (m_beat !== held_beat) begin
                    error_count++;
                    $display("Fail at time %0t: m_beat expected %h, got %h",
                             $time, held_beat, m_beat);
                end
            end
            was_stalled = m_valid && !m_ready;
            held_beat   = m_beat;

            // Output beats leave in input order.
            if (m_valid && m_ready) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Output beat at time %0t has no input pixel behind it", $time);
                end else begin
                    want = exp_q.pop_front();
                    beat_count++;
                    compare_field("m_beat.r", want.r, m_beat.r);
                    compare_field("m_beat.g", want.g, m_beat.g);
                    compare_field("m_beat.b", want.b, m_beat.b);
                    compare_field("m_beat.sof", want.sof, m_beat.sof);
                    compare_field("m_beat.eol", want.eol, m_beat.eol);
                end
            end

            // A pending request is consumed by the next accepted frame start.
            if (accept && s_beat.sof && pending) begin
                frame_phase = param_phase;
            end
            pending = in_update_req || (pending && !(accept && s_beat.sof));

            // Once the bottom-right pixel of a window arrives, its centre is known.
            if (accept) begin
                if (s_beat.sof) begin
                    row     = 0;
                    col     = 0;
                    out_idx = 0;
                end
                if (row < ROWS && col < COLS) begin
                    fpix[row][col] = s_beat.data[DATA_BITS-1:0];
                end
                if (row >= 2 && col >= 2 && row < ROWS && col < COLS) begin
                    want     = model_pixel(row - 1, col - 1);
                    // The cropped frame is frame_w - 2 pixels wide.
                    // Its first beat carries sof and each full line ends with eol.
                    want.sof = (out_idx == 0);
                    want.eol = ((out_idx + 1) % (frame_w - 2)) == 0;
                    out_idx++;
                    exp_q.push_back(want);
                end
                if (s_beat.eol) begin
                    // The first line of a frame gives its width.
                    if (row == 0) begin
                        frame_w = col + 1;
                    end
                    row++;
                    col = 0;
                end else begin
                    col++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_video_raw_to_rgb.sv
`default_nettype none

module tb_video_raw_to_rgb;
    import raw_rgb_pkg::*;

    localparam int DATA_BITS  = 10;
    localparam int MAX_COLS   = 32;
    localparam int NUM_FRAMES = 12;
    localparam int MAX_W      = 20;
    localparam int MAX_H      = 8;

    // Four cycles for every pixel of the largest possible run, plus slack.
    localparam int WATCHDOG_CYCLES = 4 * NUM_FRAMES * MAX_W * MAX_H + 1000;

    logic       clk;
    logic       rst_n;
    logic       s_valid;
    logic       s_ready;
    raw_beat_t  s_beat;
    logic       m_valid;
    logic       m_ready;
    rgb_beat_t  m_beat;
    logic       in_update_req;
    logic [1:0] param_phase;
    int         error_count;
    int         beat_count;
    int         expected_total;
    integer     seed;

    video_raw_to_rgb #(
        .DATA_BITS (DATA_BITS),
        .MAX_COLS  (MAX_COLS)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .s_beat        (s_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .m_beat        (m_beat),
        .in_update_req (in_update_req),
        .param_phase   (param_phase)
    );

    rgb_checker #(
        .DATA_BITS (DATA_BITS)
    ) u_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .s_beat        (s_beat),
        .m_valid       (m_valid),
        .m_ready       (m_ready),
        .m_beat        (m_beat),
        .in_update_req (in_update_req),
        .param_phase   (param_phase),
        .error_count   (error_count),
        .beat_count    (beat_count)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ############################################################
    // Stimulus helpers
    // ############################################################

    // Uniform pick in lo..hi. All random draws share one seed and one process.
    function automatic int pick_between(input int lo, input int hi);
        return lo + ({$random(seed)} % (hi - lo + 1));
    endfunction

    // Move to the drive point of the next cycle, with a fresh sink ready.
    // About seven cycles in ten the sink takes a beat.
    task automatic next_cycle();
        @(posedge clk);
        #1;
        m_ready = (pick_between(0, 9) < 7);
    endtask

    // Offer one beat after an optional gap and hold it until it is taken.
    // s_ready is read at the falling edge, where it no longer moves.
    task automatic send_pixel(input raw_beat_t beat);
        int gaps;
        gaps = (pick_between(0, 9) < 2) ? pick_between(1, 3) : 0;
        s_valid = 1'b0;
        repeat (gaps) next_cycle();
        s_valid = 1'b1;
        s_beat  = beat;
        @(negedge clk);
        while (!s_ready) begin
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        s_valid = 1'b0;
    endtask

    // ############################################################
    // Main sequence
    // ############################################################

    initial begin
        raw_beat_t beat;
        int        w;
        int        h;
        int        total_errors;
        seed           = 32'h7461_35c2;
        rst_n          = 1'b0;
        s_valid        = 1'b0;
        s_beat         = '0;
        m_ready        = 1'b0;
        in_update_req  = 1'b0;
        // The input starts away from RGGB, so the first frame shows
        // that only the reset value of the phase register counts.
        param_phase    = PHASE_BGGR;
        expected_total = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();

        for (int f = 0; f < NUM_FRAMES; f++) begin
            // The first frame runs on the reset phase.
            // Later ones may move param_phase with or without asking for it.
            if (f > 0) begin
                if (pick_between(0, 3) != 0) begin
                    param_phase = 2'(pick_between(0, 3));
                end
                if (pick_between(0, 1) == 1) begin
                    in_update_req = 1'b1;
                    next_cycle();
                    in_update_req = 1'b0;
                end
                next_cycle();
            end
            w = pick_between(4, MAX_W);
            h = pick_between(4, MAX_H);
            expected_total += (w - 2) * (h - 2);
            for (int r = 0; r < h; r++) begin
                for (int c = 0; c < w; c++) begin
                    beat.data = 16'(pick_between(0, (1 << DATA_BITS) - 1));
                    beat.sof  = (r == 0) && (c == 0);
                    beat.eol  = (c == w - 1);
                    send_pixel(beat);
                end
            end
        end

        // Drain, then idle a little longer so a stray extra beat would show.
        while (beat_count < expected_total) begin
            next_cycle();
        end
        repeat (20) next_cycle();

        total_errors = error_count;
        if (beat_count != expected_total) begin
            total_errors++;
            $display("Received %0d output beats but %0d were expected",
                     beat_count, expected_total);
        end
        $display("Errors: %0d, output beats checked: %0d of %0d",
                 total_errors, beat_count, expected_total);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the stimulus bounds above.
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, output stream stopped at beat %0d of %0d",
                 WATCHDOG_CYCLES, beat_count, expected_total);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/raw_rgb_pkg.sv
verilog/raw_window.sv
verilog/green_interp.sv
verilog/red_blue_interp.sv
verilog/rgb_assemble.sv
verilog/video_raw_to_rgb.sv
dv/rgb_checker.sv
dv/tb_video_raw_to_rgb.sv
